// File: board_inputs.f
+incdir+source
source/board_input_pkg.sv
source/joy_4way_filter.sv
source/joy_sync_bank.sv
source/game_input_map.sv
source/board_control.sv
source/board_inputs.sv
tests/tb_clock_gen.sv
tests/tb_board_inputs.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the board_inputs testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_board_inputs -f board_inputs.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_board_inputs 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

// File: tests/tb_board_inputs.sv
// board inputs testbench with stimulus, expected-value model and checking assertions
`timescale 1ns/1ps
`include "board_params.svh"

module tb_board_inputs;
    import board_input_pkg::*;

    localparam int RST_CYCLES  = 8;
    localparam int RAND_CYCLES = 600;
    localparam int WAY_CYCLES  = 400;
    // reset, idle, rotation, 4-way, pause, controls and drain
    localparam int FIXED_CYCLES   = 140;
    localparam int TIMEOUT_CYCLES = 2 * (FIXED_CYCLES + RAND_CYCLES + WAY_CYCLES);
    localparam logic         INV       = 1'(`BOARD_ACTIVE_LOW);
    localparam game_inputs_t GAME_IDLE = {$bits(game_inputs_t){INV}};

    // control levels as board control samples them
    typedef struct packed {
        logic                         pause;
        logic                         reset;
        logic                         osd;
        logic [`BOARD_GFX_LAYERS-1:0] gfx;
    } ctl_sample_t;

    logic                           clk_sys;
    logic                           rst;
    joy_bank_t                      board_joy;
    key_status_t                    keys;
    logic                           en_4way;
    logic                           rot_control;
    logic                           flip;
    logic                           osd_pause;
    logic                           downloading;
    game_inputs_t                   game;
    logic                           game_pause;
    logic                           soft_rst;
    logic [`BOARD_GFX_LAYERS-1:0]   gfx_en;

    // expected-value pipeline
    joy_bank_t                      filt_q;
    joy_bank_t                      bank_q;
    logic [`BOARD_PLAYERS-1:0][3:0] held_q;
    ctl_sample_t                    ctl_s1;
    ctl_sample_t                    ctl_s2;
    logic                           exp_rise;
    game_inputs_t                   exp_game;
    logic                           exp_pause;
    logic                           exp_soft_rst;
    logic [`BOARD_GFX_LAYERS-1:0]   exp_gfx;
    logic [2:0]                     way_pipe;
    logic                           idle_phase;
    logic [31:0]                    rng = 32'd6656;
    int                             cycle_cnt = 0;
    int                             err_game = 0;
    int                             err_idle = 0;
    int                             err_pause = 0;
    int                             err_soft = 0;
    int                             err_gfx = 0;
    int                             err_way = 0;

    tb_clock_gen #(.CLK_PERIOD(4), .RST_CYCLES(RST_CYCLES)) u_clk_gen (.*);

    board_inputs u_dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // a lone direction passes, a diagonal keeps only the held one
    function automatic logic [3:0] filter_nibble(input logic [3:0] nib, input logic en,
                                                 input logic [3:0] held);
        if (!en || $countones(nib) <= 1) begin
            return nib;
        end
        return nib & held;
    endfunction

    function automatic logic [3:0] held_after(input logic [3:0] nib, input logic en,
                                              input logic [3:0] held);
        if (!en || $countones(nib) <= 1) begin
            return en ? nib : 4'b0;
        end
        return held;
    endfunction

    // bit 3 up, 2 down, 1 left, 0 right
    function automatic logic [3:0] rotate_dir(input logic [3:0] d, input logic rot,
                                              input logic flp);
        logic [3:0] r;
        r = d;
        if (rot && flp) begin
            r[3] = d[1];
            r[2] = d[0];
            r[1] = d[2];
            r[0] = d[3];
        end else if (rot) begin
            r[3] = d[0];
            r[2] = d[1];
            r[1] = d[3];
            r[0] = d[2];
        end
        return r;
    endfunction

    function automatic game_inputs_t expected_game(input joy_bank_t bank, input key_status_t k,
                                                   input logic rot, input logic flp);
        game_inputs_t g;
        g.service = k.key_service;
        for (int p = 0; p < `BOARD_PLAYERS; p++) begin
            g.joy[p]   = bank.joy[p][`BOARD_GAME_JOY_W-1:0];
            g.coin[p]  = bank.joy[p][`BOARD_COIN_BIT] | k.key_coin[p];
            g.start[p] = bank.joy[p][`BOARD_START_BIT] | k.key_start[p];
        end
        // keyboard joysticks only for players 1 to 3
        for (int p = 0; p < KEY_PLAYERS; p++) begin
            g.joy[p] = g.joy[p] | k.key_joy[p];
        end
        for (int p = 0; p < `BOARD_PLAYERS; p++) begin
            g.joy[p][3:0] = rotate_dir(g.joy[p][3:0], rot, flp);
        end
        return g ^ GAME_IDLE;
    endfunction

    always @(posedge clk_sys) begin
        if (rst) begin
            filt_q       <= '0;
            bank_q       <= '0;
            held_q       <= '0;
            ctl_s1       <= '0;
            ctl_s2       <= '0;
            exp_rise     <= 1'b0;
            exp_game     <= GAME_IDLE;
            exp_pause    <= 1'b0;
            exp_soft_rst <= 1'b0;
            exp_gfx      <= '1;
            way_pipe     <= '0;
        end else begin
            for (int p = 0; p < `BOARD_PLAYERS; p++) begin
                filt_q.joy[p] <= {board_joy.joy[p][`BOARD_JOY_W-1:4],
                                  filter_nibble(board_joy.joy[p][3:0], en_4way, held_q[p])};
                held_q[p]     <= held_after(board_joy.joy[p][3:0], en_4way, held_q[p]);
            end
            bank_q       <= filt_q;
            exp_rise     <= (filt_q.joy[0][`BOARD_PAUSE_BIT] & ~bank_q.joy[0][`BOARD_PAUSE_BIT])
                          | (filt_q.joy[1][`BOARD_PAUSE_BIT] & ~bank_q.joy[1][`BOARD_PAUSE_BIT]);
            exp_game     <= expected_game(bank_q, keys, rot_control, flip);
            way_pipe     <= {way_pipe[1:0], en_4way};
            ctl_s1       <= {keys.key_pause, keys.key_reset, osd_pause, keys.key_gfx};
            ctl_s2       <= ctl_s1;
            exp_soft_rst <= ctl_s1.reset & ~ctl_s2.reset;
            exp_gfx      <= exp_gfx ^ (ctl_s1.gfx & ~ctl_s2.gfx);
            if (downloading) begin
                exp_pause <= 1'b0;
            end else if (ctl_s1.osd != ctl_s2.osd) begin
                exp_pause <= ctl_s1.osd;
            end else if ((ctl_s1.pause & ~ctl_s2.pause) | exp_rise) begin
                exp_pause <= ~exp_pause;
            end
        end
    end

    a_idle: assert property (@(posedge clk_sys) disable iff (rst)
        idle_phase |-> (game == GAME_IDLE && !game_pause && !soft_rst && gfx_en == '1))
        else begin
            err_idle = err_idle + 1;
            $display("Mismatch reset values: game %h game_pause %h soft_rst %h gfx_en %h",
                     $sampled(game), $sampled(game_pause), $sampled(soft_rst),
                     $sampled(gfx_en));
        end

    a_game: assert property (@(posedge clk_sys) disable iff (rst) game == exp_game)
        else begin
            err_game = err_game + 1;
            $display("Mismatch game: got %h expected %h", $sampled(game), $sampled(exp_game));
        end

    a_pause: assert property (@(posedge clk_sys) disable iff (rst) game_pause == exp_pause)
        else begin
            err_pause = err_pause + 1;
            $display("Mismatch game_pause: got %h expected %h",
                     $sampled(game_pause), $sampled(exp_pause));
        end

    a_soft: assert property (@(posedge clk_sys) disable iff (rst) soft_rst == exp_soft_rst)
        else begin
            err_soft = err_soft + 1;
            $display("Mismatch soft_rst: got %h expected %h",
                     $sampled(soft_rst), $sampled(exp_soft_rst));
        end

    a_gfx: assert property (@(posedge clk_sys) disable iff (rst) gfx_en == exp_gfx)
        else begin
            err_gfx = err_gfx + 1;
            $display("Mismatch gfx_en: got %h expected %h", $sampled(gfx_en), $sampled(exp_gfx));
        end

    // player 4 has no key merge, so its nibble shows the filter directly
    a_way: assert property (@(posedge clk_sys) disable iff (rst)
        way_pipe[2] |-> $onehot0(game.joy[3][3:0] ^ {4{INV}}))
        else begin
            err_way = err_way + 1;
            $display("4-way filter let several directions through, nibble %h",
                     $sampled(game.joy[3][3:0]));
        end

    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic advance(input int n);
        repeat (n) begin
            @(posedge clk_sys);
            #1;
        end
    endtask

    // random board words, plus random keys unless the 4-way filter is under test
    task automatic random_traffic(input int n, input logic way);
        logic [63:0] wide;
        for (int i = 0; i < n; i++) begin
            rng = xorshift32(rng);
            wide[63:32] = rng;
            rng = xorshift32(rng);
            wide[31:0] = rng;
            board_joy = wide;
            if (!way) begin
                rng = xorshift32(rng);
                wide[31:0] = rng;
                keys = wide[45:0];
            end
            advance(1);
        end
    endtask

    initial begin
        board_joy   = '0;
        keys        = '0;
        en_4way     = 1'b0;
        rot_control = 1'b0;
        flip        = 1'b0;
        osd_pause   = 1'b0;
        downloading = 1'b0;
        idle_phase  = 1'b1;
        @(negedge rst);
        advance(5);
        idle_phase = 1'b0;
        random_traffic(RAND_CYCLES, 1'b0);
        keys = '0;
        // single directions through the rotation, flip high then low
        rot_control = 1'b1;
        for (int f = 1; f >= 0; f--) begin
            flip = f[0];
            for (int d = 0; d < 4; d++) begin
                board_joy = {`BOARD_PLAYERS{16'(1 << d)}};
                advance(4);
            end
        end
        rot_control = 1'b0;
        flip = 1'b0;
        // right, then right with up, then up alone
        en_4way = 1'b1;
        board_joy = {`BOARD_PLAYERS{16'h0001}};
        advance(4);
        board_joy = {`BOARD_PLAYERS{16'h0009}};
        advance(4);
        board_joy = {`BOARD_PLAYERS{16'h0008}};
        advance(4);
        random_traffic(WAY_CYCLES, 1'b1);
        en_4way = 1'b0;
        board_joy = '0;
        advance(4);
        // key pause, then player 2 pause button
        keys.key_pause = 1'b1;
        advance(4);
        keys.key_pause = 1'b0;
        advance(4);
        board_joy.joy[1][`BOARD_PAUSE_BIT] = 1'b1;
        advance(5);
        board_joy.joy[1][`BOARD_PAUSE_BIT] = 1'b0;
        advance(4);
        osd_pause = 1'b1;
        advance(4);
        osd_pause = 1'b0;
        advance(4);
        osd_pause = 1'b1;
        advance(3);
        downloading = 1'b1;
        advance(4);
        downloading = 1'b0;
        advance(2);
        osd_pause = 1'b0;
        advance(4);
        keys.key_reset = 1'b1;
        advance(5);
        keys.key_reset = 1'b0;
        advance(3);
        for (int g = 0; g < `BOARD_GFX_LAYERS; g++) begin
            keys.key_gfx[g] = 1'b1;
            advance(3);
            keys.key_gfx[g] = 1'b0;
            advance(3);
        end
        advance(6);
        $display("errors game %0d reset %0d pause %0d soft_rst %0d gfx_en %0d 4-way %0d",
                 err_game, err_idle, err_pause, err_soft, err_gfx, err_way);
        if (err_game + err_idle + err_pause + err_soft + err_gfx + err_way == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock_gen.sv
// testbench clock source and power-on reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int CLK_PERIOD = 4,
    parameter int RST_CYCLES = 8
) (
    output logic clk_sys,
    output logic rst
);

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    // released just after an edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_sys);
        #1;
        rst = 1'b0;
    end

endmodule

// File: source/board_inputs.sv
// player input top: 4-way filters, sync bank, game input mapper and board control
`timescale 1ns/1ps
`include "board_params.svh"

module board_inputs (
    input  logic                          clk_sys,
    input  logic                          rst,
    input  board_input_pkg::joy_bank_t    board_joy,
    input  board_input_pkg::key_status_t  keys,
    input  logic                          en_4way,
    input  logic                          rot_control,
    input  logic                          flip,
    input  logic                          osd_pause,
    input  logic                          downloading,
    output board_input_pkg::game_inputs_t game,
    output logic                          game_pause,
    output logic                          soft_rst,
    output logic [`BOARD_GFX_LAYERS-1:0]  gfx_en
);
    import board_input_pkg::*;

    joy_bank_t joy_4way;
    joy_bank_t joy_sync;
    logic      joy_pause_rise;

    joy_4way_filter u_4way_1p (
        .clk_sys (clk_sys),
        .rst     (rst),
        .enable  (en_4way),
        .joy_in  (board_joy.joy[0]),
        .joy_out (joy_4way.joy[0])
    );

    joy_4way_filter u_4way_2p (
        .clk_sys (clk_sys),
        .rst     (rst),
        .enable  (en_4way),
        .joy_in  (board_joy.joy[1]),
        .joy_out (joy_4way.joy[1])
    );

    joy_4way_filter u_4way_3p (
        .clk_sys (clk_sys),
        .rst     (rst),
        .enable  (en_4way),
        .joy_in  (board_joy.joy[2]),
        .joy_out (joy_4way.joy[2])
    );

    joy_4way_filter u_4way_4p (
        .clk_sys (clk_sys),
        .rst     (rst),
        .enable  (en_4way),
        .joy_in  (board_joy.joy[3]),
        .joy_out (joy_4way.joy[3])
    );

    joy_sync_bank u_sync_bank (
        .clk_sys        (clk_sys),
        .rst            (rst),
        .joy_in         (joy_4way),
        .joy_sync       (joy_sync),
        .joy_pause_rise (joy_pause_rise)
    );

    game_input_map u_game_map (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .joy_sync    (joy_sync),
        .keys        (keys),
        .rot_control (rot_control),
        .flip        (flip),
        .game        (game)
    );

    board_control u_board_ctl (
        .clk_sys        (clk_sys),
        .rst            (rst),
        .keys           (keys),
        .joy_pause_rise (joy_pause_rise),
        .osd_pause      (osd_pause),
        .downloading    (downloading),
        .game_pause     (game_pause),
        .soft_rst       (soft_rst),
        .gfx_en         (gfx_en)
    );

endmodule

// File: source/board_control.sv
// pause state, soft reset pulse and graphics layer enable toggles
`timescale 1ns/1ps
`include "board_params.svh"

module board_control (
    input  logic                         clk_sys,
    input  logic                         rst,
    input  board_input_pkg::key_status_t keys,
    input  logic                         joy_pause_rise,
    input  logic                         osd_pause,
    input  logic                         downloading,
    output logic                         game_pause,
    output logic                         soft_rst,
    output logic [`BOARD_GFX_LAYERS-1:0] gfx_en
);

    // sampled control levels
    typedef struct packed {
        logic                         pause;
        logic                         reset;
        logic                         osd;
        logic [`BOARD_GFX_LAYERS-1:0] gfx;
    } ctl_t;

    ctl_t ctl_q;
    ctl_t ctl_last;
    logic pause_toggle;

    assign pause_toggle = (ctl_q.pause & ~ctl_last.pause) | joy_pause_rise;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            ctl_q      <= '0;
            ctl_last   <= '0;
            soft_rst   <= 1'b0;
            gfx_en     <= '1;
            game_pause <= 1'b0;
        end else begin
            ctl_q.pause <= keys.key_pause;
            ctl_q.reset <= keys.key_reset;
            ctl_q.osd   <= osd_pause;
            ctl_q.gfx   <= keys.key_gfx;
            ctl_last    <= ctl_q;

            soft_rst <= ctl_q.reset & ~ctl_last.reset;
            // each layer flips on its own key press
            gfx_en   <= gfx_en ^ (ctl_q.gfx & ~ctl_last.gfx);

            // download wins, then an OSD change, then the toggle
            if (downloading) begin
                game_pause <= 1'b0;
            end else if (ctl_q.osd != ctl_last.osd) begin
                game_pause <= ctl_q.osd;
            end else if (pause_toggle) begin
                game_pause <= ~game_pause;
            end
        end
    end

    a_rst_pulse: assert property (@(posedge clk_sys) disable iff (rst)
        soft_rst |=> !soft_rst)
        else $error("soft_rst held for more than one cycle");

endmodule

// File: source/game_input_map.sv
// rotation, key merge and polarity into game joysticks, coin, start and service
`timescale 1ns/1ps
`include "board_params.svh"

module game_input_map (
    input  logic                          clk_sys,
    input  logic                          rst,
    input  board_input_pkg::joy_bank_t    joy_sync,
    input  board_input_pkg::key_status_t  keys,
    input  logic                          rot_control,
    input  logic                          flip,
    output board_input_pkg::game_inputs_t game
);
    import board_input_pkg::*;

    localparam logic         INV       = 1'(`BOARD_ACTIVE_LOW);
    localparam game_inputs_t GAME_IDLE = {$bits(game_inputs_t){INV}};

    logic [`BOARD_PLAYERS-1:0][`BOARD_GAME_JOY_W-1:0] key_joy_all;
    game_inputs_t                                     game_d;

    // bit 0 right, 1 left, 2 down, 3 up
    function automatic logic [`BOARD_GAME_JOY_W-1:0] rotate_joy(
        input logic [`BOARD_GAME_JOY_W-1:0] joy,
        input logic                         rot,
        input logic                         flp
    );
        logic [3:0] dir;
        dir = joy[3:0];
        if (rot) begin
            if (flp) begin
                dir = {joy[1], joy[0], joy[2], joy[3]};
            end else begin
                dir = {joy[0], joy[1], joy[3], joy[2]};
            end
        end
        return {joy[`BOARD_GAME_JOY_W-1:4], dir};
    endfunction

    // player 4 has no keyboard joystick
    assign key_joy_all = {{`BOARD_GAME_JOY_W{1'b0}}, keys.key_joy};

    always_comb begin
        game_d.service = keys.key_service;
        for (int p = 0; p < `BOARD_PLAYERS; p++) begin
            game_d.joy[p]   = rotate_joy(
                joy_sync.joy[p][`BOARD_GAME_JOY_W-1:0] | key_joy_all[p],
                rot_control, flip);
            game_d.coin[p]  = joy_sync.joy[p][`BOARD_COIN_BIT] | keys.key_coin[p];
            game_d.start[p] = joy_sync.joy[p][`BOARD_START_BIT] | keys.key_start[p];
        end
    end

    // idle pattern doubles as the inversion mask
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game <= GAME_IDLE;
        end else begin
            game <= game_d ^ GAME_IDLE;
        end
    end

endmodule

// File: source/joy_sync_bank.sv
// synchronised joystick bank with pause rising-edge flag for players 1 and 2
`timescale 1ns/1ps
`include "board_params.svh"

module joy_sync_bank (
    input  logic                       clk_sys,
    input  logic                       rst,
    input  board_input_pkg::joy_bank_t joy_in,
    output board_input_pkg::joy_bank_t joy_sync,
    output logic                       joy_pause_rise
);

    logic [1:0] pause_new;
    logic [1:0] pause_old;

    // joy_sync still holds the last sample, so it is the history
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            pause_new[p] = joy_in.joy[p][`BOARD_PAUSE_BIT];
            pause_old[p] = joy_sync.joy[p][`BOARD_PAUSE_BIT];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            joy_sync       <= '0;
            joy_pause_rise <= 1'b0;
        end else begin
            joy_sync       <= joy_in;
            // flag goes out together with the word that rose
            joy_pause_rise <= |(pause_new & ~pause_old);
        end
    end

endmodule

// File: source/joy_4way_filter.sv
// 4-way joystick filter, one register stage per player word
`timescale 1ns/1ps
`include "board_params.svh"

module joy_4way_filter (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  logic                    enable,
    input  logic [`BOARD_JOY_W-1:0] joy_in,
    output logic [`BOARD_JOY_W-1:0] joy_out
);
    import board_input_pkg::*;

    joy_dir_e   dir_q;
    joy_dir_e   dir_d;
    logic [3:0] nib_d;

    // one-hot nibble for a stored direction
    function automatic logic [3:0] dir_mask(input joy_dir_e dir);
        case (dir)
            DIR_RIGHT: return 4'b0001;
            DIR_LEFT:  return 4'b0010;
            DIR_DOWN:  return 4'b0100;
            DIR_UP:    return 4'b1000;
            default:   return 4'b0000;
        endcase
    endfunction

    always_comb begin
        dir_d = DIR_NONE;
        nib_d = joy_in[3:0];
        if (enable) begin
            dir_d = dir_q;
            case (joy_in[3:0])
                4'b0000: dir_d = DIR_NONE;
                4'b0001: dir_d = DIR_RIGHT;
                4'b0010: dir_d = DIR_LEFT;
                4'b0100: dir_d = DIR_DOWN;
                4'b1000: dir_d = DIR_UP;
                // diagonal, keep the held direction only if still pressed
                default: nib_d = joy_in[3:0] & dir_mask(dir_q);
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dir_q <= DIR_NONE;
        end else begin
            dir_q <= dir_d;
        end
    end

    always_ff @(posedge clk_sys) begin
        joy_out <= {joy_in[`BOARD_JOY_W-1:4], nib_d};
    end

    a_one_dir: assert property (@(posedge clk_sys) disable iff (rst)
        enable |=> $onehot0(joy_out[3:0]))
        else $error("4-way output has more than one direction: %h", joy_out[3:0]);

endmodule

// File: source/board_input_pkg.sv
// direction enum and packed structs for joystick banks, decoded keys and game inputs
`include "board_params.svh"

package board_input_pkg;

    // players that also have keyboard joysticks
    localparam int KEY_PLAYERS = 3;

    // last single direction held by a 4-way filter
    typedef enum logic [2:0] {
        DIR_NONE,
        DIR_RIGHT,
        DIR_LEFT,
        DIR_DOWN,
        DIR_UP
    } joy_dir_e;

    // board joystick words, player 1 at index 0
    typedef struct packed {
        logic [`BOARD_PLAYERS-1:0][`BOARD_JOY_W-1:0] joy;
    } joy_bank_t;

    // keys from the keyboard decoder
    typedef struct packed {
        logic [KEY_PLAYERS-1:0][`BOARD_GAME_JOY_W-1:0] key_joy;
        logic [`BOARD_PLAYERS-1:0]                     key_start;
        logic [`BOARD_PLAYERS-1:0]                     key_coin;
        logic                                          key_reset;
        logic                                          key_pause;
        logic                                          key_service;
        logic                                          key_test;
        logic [`BOARD_GFX_LAYERS-1:0]                  key_gfx;
    } key_status_t;

    // inputs as the game core sees them
    typedef struct packed {
        logic [`BOARD_PLAYERS-1:0][`BOARD_GAME_JOY_W-1:0] joy;
        logic [`BOARD_PLAYERS-1:0]                        coin;
        logic [`BOARD_PLAYERS-1:0]                        start;
        logic                                             service;
    } game_inputs_t;

endpackage

// File: source/board_params.svh
// board input widths, player and button counts, bit positions, polarity and gfx layers
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// word widths
`define BOARD_JOY_W       16
`define BOARD_GAME_JOY_W  10

`define BOARD_PLAYERS     4
`define BOARD_BUTTONS     2

// start, coin and pause sit just above the buttons
`define BOARD_START_BIT   (6 + (`BOARD_BUTTONS - 2))
`define BOARD_COIN_BIT    (7 + (`BOARD_BUTTONS - 2))
`define BOARD_PAUSE_BIT   (8 + (`BOARD_BUTTONS - 2))

// 1 means the game expects active-low inputs
`define BOARD_ACTIVE_LOW  1

`define BOARD_GFX_LAYERS  4

`endif
